//--- design/hub_pkg.sv
//////////////////////////////////////////////////
// hub shared types: data byte, frame length and
// the state encodings of the port and scheduler FSMs
//////////////////////////////////////////////////

`default_nettype none

package hub_pkg;

  // one byte on a hub port
  typedef logic [7:0] byte_t;

  // frame length in bytes
  typedef logic [15:0] len_t;

  //////////////////////////////////////////////////
  // state machines
  //////////////////////////////////////////////////

  // receive port service side of the req/ack handshake
  typedef enum logic [1:0] {
    IDLE,
    SERVE,
    RELEASE
  } rx_state_e;

  // transmit scheduler
  typedef enum logic [1:0] {
    PICK,
    SEND,
    GAP
  } tx_state_e;

endpackage

`default_nettype wire

//--- design/hub_frame_fifo.sv
//////////////////////////////////////////////////
// frame byte buffer, fall-through read, with a
// committed write pointer so a partial frame can be dropped
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hub_frame_fifo #(
  parameter int BUF_DEPTH = 64
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           wr,
  input  hub_pkg::byte_t wr_data,
  input  logic           commit,
  input  logic           abort,
  input  logic           rd,
  output hub_pkg::byte_t rd_data,
  output logic           full
);

  localparam int AW = $clog2(BUF_DEPTH);

  hub_pkg::byte_t mem [BUF_DEPTH];

  // extra msb tells full from empty
  logic [AW:0] wr_ptr;
  logic [AW:0] cmt_ptr;
  logic [AW:0] rd_ptr;
  logic        has_data;

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr[AW-1:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      cmt_ptr <= '0;
      rd_ptr  <= '0;
    end else begin
      // abort rolls back to the last whole frame
      if (abort) begin
        wr_ptr <= cmt_ptr;
      end else if (wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (commit) begin
        cmt_ptr <= wr_ptr;
      end
      if (rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // uncommitted bytes still take up room
  assign full     = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign has_data = cmt_ptr != rd_ptr;
  assign rd_data  = mem[rd_ptr[AW-1:0]];

  a_rd_committed: assert property (@(posedge clk) disable iff (rst) rd |-> has_data);
  a_wr_room:      assert property (@(posedge clk) disable iff (rst) wr |-> !full);

endmodule

`default_nettype wire

//--- design/hub_rx_port.sv
//////////////////////////////////////////////////
// hub receive port: assembles frames into a buffer
// and hands one frame per req/ack cycle to the scheduler
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hub_rx_port #(
  parameter int BUF_DEPTH = 64
) (
  input  logic           clk,
  input  logic           rst,
  input  hub_pkg::byte_t din,
  input  logic           vin,
  input  logic           ack,
  input  logic           pop,
  output logic           req,
  output hub_pkg::byte_t head,
  output logic           last
);

  // a quarter of the byte depth, frames are rarely tiny
  localparam int LQ_DEPTH = BUF_DEPTH / 4;
  localparam int LAW      = $clog2(LQ_DEPTH);

  logic              in_frame;
  logic              ovf;
  hub_pkg::len_t     frame_len;
  logic              frame_end;
  logic              frame_ok;
  logic              fifo_wr;
  logic              fifo_full;
  hub_pkg::len_t     lq_mem [LQ_DEPTH];
  logic [LAW:0]      lq_wr;
  logic [LAW:0]      lq_rd;
  logic              lq_full;
  logic              lq_empty;
  hub_pkg::rx_state_e state;
  hub_pkg::len_t     remain;

  //////////////////////////////////////////////////
  // receive side
  //////////////////////////////////////////////////

  assign frame_end = in_frame && !vin;
  // once a byte is lost the rest of the frame is not stored
  assign fifo_wr   = vin && !ovf && !fifo_full;
  assign frame_ok  = frame_end && !ovf && !lq_full;

  assign lq_full  = (lq_wr[LAW] != lq_rd[LAW]) && (lq_wr[LAW-1:0] == lq_rd[LAW-1:0]);
  assign lq_empty = lq_wr == lq_rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_frame  <= 1'b0;
      ovf       <= 1'b0;
      frame_len <= '0;
      lq_wr     <= '0;
    end else begin
      if (vin) begin
        in_frame  <= 1'b1;
        frame_len <= in_frame ? frame_len + 1'b1 : hub_pkg::len_t'(1);
        if (fifo_full) begin
          ovf <= 1'b1;
        end
      end else if (in_frame) begin
        in_frame <= 1'b0;
        ovf      <= 1'b0;
      end
      if (frame_ok) begin
        lq_wr <= lq_wr + 1'b1;
      end
    end
  end

  // length becomes visible the cycle after vin falls
  always_ff @(posedge clk) begin
    if (frame_ok) begin
      lq_mem[lq_wr[LAW-1:0]] <= frame_len;
    end
  end

  hub_frame_fifo #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .rst     (rst),
    .wr      (fifo_wr),
    .wr_data (din),
    .commit  (frame_ok),
    .abort   (frame_end && !frame_ok),
    .rd      (pop),
    .rd_data (head),
    .full    (fifo_full)
  );

  //////////////////////////////////////////////////
  // service side, four-phase handshake
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= hub_pkg::IDLE;
      remain <= '0;
      lq_rd  <= '0;
    end else begin
      case (state)
        hub_pkg::IDLE: begin
          // previous ack must be seen low first
          if (!lq_empty && !ack) begin
            state  <= hub_pkg::SERVE;
            remain <= lq_mem[lq_rd[LAW-1:0]];
          end
        end
        hub_pkg::SERVE: begin
          if (pop) begin
            remain <= remain - 1'b1;
            if (last) begin
              lq_rd <= lq_rd + 1'b1;
              state <= hub_pkg::RELEASE;
            end
          end
        end
        hub_pkg::RELEASE: begin
          if (!ack) begin
            state <= hub_pkg::IDLE;
          end
        end
        default: state <= hub_pkg::IDLE;
      endcase
    end
  end

  assign req  = state == hub_pkg::SERVE;
  assign last = (state == hub_pkg::SERVE) && (remain == hub_pkg::len_t'(1));

  a_pop_acked: assert property (@(posedge clk) disable iff (rst) pop |-> ack);

endmodule

`default_nettype wire

//--- design/hub_tx_sched.sv
//////////////////////////////////////////////////
// hub scheduler: round-robin frame grant, broadcast
// to every port but the source, inter-frame gap
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hub_tx_sched #(
  parameter int N_PORTS = 3,
  parameter int IFG     = 10
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic           [N_PORTS-1:0]       req,
  input  hub_pkg::byte_t [N_PORTS-1:0]       head,
  input  logic           [N_PORTS-1:0]       last,
  output logic           [N_PORTS-1:0]       ack,
  output logic           [N_PORTS-1:0]       pop,
  output hub_pkg::byte_t [N_PORTS-1:0]       dout,
  output logic           [N_PORTS-1:0]       vout
);

  localparam int PW = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;
  localparam int GW = $clog2(IFG + 1);
  // first gap cycle still carries the last byte out
  localparam logic [GW-1:0] GAP_LAST = GW'(IFG - 1);

  hub_pkg::tx_state_e state;
  logic [PW-1:0]      src;
  logic [GW-1:0]      gap_cnt;
  logic               pick_ok;
  logic [PW-1:0]      pick_idx;

  //////////////////////////////////////////////////
  // round-robin search
  //////////////////////////////////////////////////

  // nearest requester after src wins, so scan from far to near
  always_comb begin
    int idx;
    pick_ok  = 1'b0;
    pick_idx = src;
    for (int k = N_PORTS; k >= 1; k--) begin
      idx = (int'(src) + k) % N_PORTS;
      if (req[idx]) begin
        pick_ok  = 1'b1;
        pick_idx = PW'(idx);
      end
    end
  end

  // one byte per SEND cycle from the granted port
  always_comb begin
    pop = '0;
    if (state == hub_pkg::SEND) begin
      pop[src] = 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // scheduler FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= hub_pkg::PICK;
      // port 0 goes first after reset
      src     <= PW'(N_PORTS - 1);
      ack     <= '0;
      gap_cnt <= '0;
      vout    <= '0;
    end else begin
      for (int i = 0; i < N_PORTS; i++) begin
        vout[i] <= (state == hub_pkg::SEND) && (i != int'(src));
      end
      case (state)
        hub_pkg::PICK: begin
          if (pick_ok) begin
            src           <= pick_idx;
            ack           <= '0;
            ack[pick_idx] <= 1'b1;
            state         <= hub_pkg::SEND;
          end
        end
        hub_pkg::SEND: begin
          if (last[src]) begin
            gap_cnt <= '0;
            state   <= hub_pkg::GAP;
          end
        end
        hub_pkg::GAP: begin
          // ack falls only once the port has dropped req
          if (!req[src]) begin
            ack <= '0;
          end
          if (gap_cnt != GAP_LAST) begin
            gap_cnt <= gap_cnt + 1'b1;
          end else if (ack == '0) begin
            state <= hub_pkg::PICK;
          end
        end
        default: state <= hub_pkg::PICK;
      endcase
    end
  end

  // output data, qualified by vout
  always_ff @(posedge clk) begin
    for (int i = 0; i < N_PORTS; i++) begin
      dout[i] <= head[src];
    end
  end

  a_one_ack: assert property (@(posedge clk) disable iff (rst) $onehot0(ack));
  a_no_echo: assert property (@(posedge clk) disable iff (rst) (vout & ack) == '0);

endmodule

`default_nettype wire

//--- design/hub_top.sv
//////////////////////////////////////////////////
// passive byte-stream hub, one receive buffer per
// port feeding a shared broadcast scheduler
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hub_top #(
  parameter int N_PORTS   = 3,
  parameter int IFG       = 10,
  parameter int BUF_DEPTH = 64
) (
  input  logic                         clk,
  input  logic                         rst,
  input  hub_pkg::byte_t [N_PORTS-1:0] din,
  input  logic           [N_PORTS-1:0] vin,
  output hub_pkg::byte_t [N_PORTS-1:0] dout,
  output logic           [N_PORTS-1:0] vout
);

  // req/ack handshake, one lane per port
  logic           [N_PORTS-1:0] req;
  logic           [N_PORTS-1:0] ack;
  logic           [N_PORTS-1:0] pop;
  logic           [N_PORTS-1:0] last;
  hub_pkg::byte_t [N_PORTS-1:0] head;

  generate
    for (genvar g = 0; g < N_PORTS; g++) begin : gen_port
      hub_rx_port #(
        .BUF_DEPTH (BUF_DEPTH)
      ) u_rx (
        .clk  (clk),
        .rst  (rst),
        .din  (din[g]),
        .vin  (vin[g]),
        .ack  (ack[g]),
        .pop  (pop[g]),
        .req  (req[g]),
        .head (head[g]),
        .last (last[g])
      );
    end
  endgenerate

  hub_tx_sched #(
    .N_PORTS (N_PORTS),
    .IFG     (IFG)
  ) u_sched (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .head (head),
    .last (last),
    .ack  (ack),
    .pop  (pop),
    .dout (dout),
    .vout (vout)
  );

endmodule

`default_nettype wire

//--- bench/hub_tb.sv
//////////////////////////////////////////////////
// hub testbench: directed frame tests checked by
// per-port output monitors, with a watchdog
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hub_tb;

  localparam int N          = 3;
  localparam int IFG        = 10;
  localparam int BUF_DEPTH  = 64;
  localparam int MAX_BYTES  = 256;
  localparam int MAX_FRAMES = 8;
  localparam int SETTLE     = 2 * IFG + 4;
  // 13 frames of 273 bytes in all, 7 settle waits, each test resets
  localparam int WATCHDOG_CYCLES = 4 * (273 + 13 * (IFG + 8) + 7 * (SETTLE + 8));

  logic                   clk;
  logic                   rst;
  hub_pkg::byte_t [N-1:0] din;
  logic           [N-1:0] vin;
  hub_pkg::byte_t [N-1:0] dout;
  logic           [N-1:0] vout;
  string                  test_name;

  // expected traffic per output port, filled as frames are sent
  hub_pkg::byte_t exp_data [N][MAX_BYTES];
  hub_pkg::len_t  exp_len  [N][MAX_FRAMES];
  int             exp_bytes  [N];
  int             exp_frames [N];
  // monitor state
  int             rx_bytes  [N];
  int             rx_frames [N];
  int             cur_len   [N];
  int             idle_run  [N];

  hub_top #(
    .N_PORTS   (N),
    .IFG       (IFG),
    .BUF_DEPTH (BUF_DEPTH)
  ) UUT (
    .clk  (clk),
    .rst  (rst),
    .din  (din),
    .vin  (vin),
    .dout (dout),
    .vout (vout)
  );

  always #50 clk = ~clk;

  //////////////////////////////////////////////////
  // output monitors, sampled mid-cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    for (int p = 0; p < N; p++) begin
      if (rst) begin
        rx_bytes[p]  = 0;
        rx_frames[p] = 0;
        cur_len[p]   = 0;
        idle_run[p]  = 0;
      end else if (vout[p]) begin
        // idle run before a frame is its gap
        if (cur_len[p] == 0 && rx_frames[p] > 0) begin
          check_gap($sformatf("%s port %0d gap", test_name, p), idle_run[p]);
        end
        if (rx_bytes[p] >= exp_bytes[p]) begin
          $display("Error: %s, port %0d sent a byte that no frame accounts for",
                   test_name, p);
          stop_run();
        end
        check_byte($sformatf("%s port %0d byte %0d", test_name, p, rx_bytes[p]),
                   exp_data[p][rx_bytes[p]], dout[p]);
        rx_bytes[p]++;
        cur_len[p]++;
      end else if (cur_len[p] > 0) begin
        check_len($sformatf("%s port %0d frame %0d length", test_name, p, rx_frames[p]),
                  exp_len[p][rx_frames[p]], hub_pkg::len_t'(cur_len[p]));
        rx_frames[p]++;
        cur_len[p]  = 0;
        idle_run[p] = 1;
      end else begin
        idle_run[p]++;
      end
    end
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic stop_run();
    $display("FAIL: see errors above");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_byte(input string what, input hub_pkg::byte_t exp,
                            input hub_pkg::byte_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %02h, actual %02h", what, exp, act);
      stop_run();
    end
  endtask

  task automatic check_len(input string what, input hub_pkg::len_t exp,
                           input hub_pkg::len_t act);
    if (act !== exp) begin
      $display("Fail %s: expected %0d, actual %0d", what, exp, act);
      stop_run();
    end
  endtask

  task automatic check_gap(input string what, input int act);
    if (act < IFG) begin
      $display("Fail %s: expected at least %0d idle cycles, actual %0d", what, IFG, act);
      stop_run();
    end
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic apply_reset(input string name);
    test_name = name;
    @(posedge clk);
    rst <= 1'b1;
    vin <= '0;
    for (int p = 0; p < N; p++) begin
      exp_bytes[p]  = 0;
      exp_frames[p] = 0;
    end
    repeat (4) @(posedge clk);
    rst <= 1'b0;
  endtask

  // frames on all ports start together, a zero length sends nothing
  task automatic send_frames(input int l0, input int l1, input int l2, input bit deliver);
    int             lens [N];
    int             longest;
    hub_pkg::byte_t payload [N][MAX_BYTES];
    lens[0] = l0;
    lens[1] = l1;
    lens[2] = l2;
    longest = 0;
    for (int p = 0; p < N; p++) begin
      longest = (lens[p] > longest) ? lens[p] : longest;
      for (int b = 0; b < lens[p]; b++) begin
        payload[p][b] = hub_pkg::byte_t'($urandom);
      end
      // copy to every port but the source, round-robin order from reset
      for (int q = 0; q < N; q++) begin
        if (deliver && lens[p] > 0 && q != p) begin
          for (int b = 0; b < lens[p]; b++) begin
            exp_data[q][exp_bytes[q] + b] = payload[p][b];
          end
          exp_bytes[q] += lens[p];
          exp_len[q][exp_frames[q]] = hub_pkg::len_t'(lens[p]);
          exp_frames[q]++;
        end
      end
    end
    // one trailing idle cycle ends the longest frame
    for (int c = 0; c <= longest; c++) begin
      @(posedge clk);
      for (int p = 0; p < N; p++) begin
        vin[p] <= c < lens[p];
        din[p] <= (c < lens[p]) ? payload[p][c] : 8'h00;
      end
    end
  endtask

  task automatic finish_case();
    bit done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      done = 1'b1;
      for (int p = 0; p < N; p++) begin
        done = done && (rx_frames[p] >= exp_frames[p]);
      end
    end
    repeat (SETTLE) @(posedge clk);
    for (int p = 0; p < N; p++) begin
      check_len($sformatf("%s port %0d frame count", test_name, p),
                hub_pkg::len_t'(exp_frames[p]), hub_pkg::len_t'(rx_frames[p]));
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////

  task automatic single_frame();
    apply_reset("single_frame");
    send_frames(24, 0, 0, 1'b1);
    finish_case();
  endtask

  // equal lengths, so all three become eligible in the same cycle
  task automatic simultaneous_frames();
    apply_reset("simultaneous_frames");
    send_frames(20, 20, 20, 1'b1);
    finish_case();
  endtask

  // short frames, so the gap rule dominates
  task automatic minimum_gap();
    apply_reset("minimum_gap");
    send_frames(0, 3, 3, 1'b1);
    finish_case();
  endtask

  task automatic back_to_back();
    apply_reset("back_to_back");
    send_frames(20, 0, 0, 1'b1);
    send_frames(25, 0, 0, 1'b1);
    finish_case();
  endtask

  task automatic oversize_drop();
    apply_reset("oversize_drop");
    send_frames(0, BUF_DEPTH + 6, 0, 1'b0);
    finish_case();
    send_frames(0, 16, 0, 1'b1);
    finish_case();
  endtask

  task automatic reset_mid_frame();
    apply_reset("reset_mid_frame");
    send_frames(30, 0, 0, 1'b1);
    while (vout[1] !== 1'b1) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    @(negedge clk);
    if (vout !== '0) begin
      $display("Error: reset_mid_frame, vout stayed high with reset asserted");
      stop_run();
    end
    apply_reset("reset_mid_frame");
    // port 0 was served last, yet wins again after reset
    send_frames(11, 11, 0, 1'b1);
    finish_case();
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    din       = '0;
    vin       = '0;
    test_name = "startup";
    void'($urandom(32'h542c23c3));
    single_frame();
    simultaneous_frames();
    minimum_gap();
    back_to_back();
    oversize_drop();
    reset_mid_frame();
    $display("PASS: all tests");
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * 100);
    $display("Error: watchdog expired after %0d cycles, the tests did not finish",
             WATCHDOG_CYCLES);
    stop_run();
  end

endmodule

`default_nettype wire

//--- verilog.f
design/hub_pkg.sv
design/hub_frame_fifo.sv
design/hub_rx_port.sv
design/hub_tx_sched.sv
design/hub_top.sv
bench/hub_tb.sv

//--- run.sh
#!/bin/sh
# build and run the hub testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module hub_tb -f verilog.f -o hub_sim

out="$(./obj_dir/hub_sim 2>&1 || true)"
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^PASS: all tests$'; then
  exit 0
fi
exit 1
